// ==== rtl/vic_defines.svh ====
`ifndef VIC_DEFINES_SVH
`define VIC_DEFINES_SVH

// Chip strap codes
`define CHIP_6567R56A 2'd0
`define CHIP_6567R8   2'd1
`define CHIP_6569     2'd2
`define CHIP_UNUSED   2'd3

// clk_dot4x ticks per CPU cycle is 2**PHASE_BITS
`define PHASE_BITS 5

// xpos values at line start and during the R8 hold
`define XPOS_START_NTSC 10'h19C
`define XPOS_START_PAL  10'h194
`define XPOS_HOLD_R8    10'h184

// Last raster_x, last raster line and CPU cycles per line
`define X_MAX_6569    10'd503
`define X_MAX_R8      10'd519
`define X_MAX_R56A    10'd511
`define Y_MAX_6569    9'd311
`define Y_MAX_R8      9'd262
`define Y_MAX_R56A    9'd261
`define CYCLES_6569   7'd63
`define CYCLES_R8     7'd65
`define CYCLES_R56A   7'd64

`endif

// ==== rtl/vic_pkg.sv ====
`default_nettype none

`include "vic_defines.svh"

package vic_pkg;

    // Dot strobes, CPU phase and cycle within the line
    typedef struct packed {
        logic       clk_phi;
        logic       dot_rising_0;
        logic       dot_rising_2;
        logic [6:0] cycle_num;
    } dot_timing_t;

    // Beam position as seen by the rest of the chip
    typedef struct packed {
        logic [9:0]  xpos;
        logic [9:0]  raster_x;
        logic [9:0]  sprite_raster_x;
        logic [8:0]  raster_line;
        logic [8:0]  raster_line_d;
        logic [10:0] hires_raster_x;
        logic [6:0]  blink_ctr;
    } raster_pos_t;

    function automatic logic [9:0] chip_x_max(input logic [1:0] chip);
        case (chip)
            `CHIP_6567R8:   return `X_MAX_R8;
            `CHIP_6567R56A: return `X_MAX_R56A;
            default:        return `X_MAX_6569;
        endcase
    endfunction

    function automatic logic [8:0] chip_y_max(input logic [1:0] chip);
        case (chip)
            `CHIP_6567R8:   return `Y_MAX_R8;
            `CHIP_6567R56A: return `Y_MAX_R56A;
            default:        return `Y_MAX_6569;
        endcase
    endfunction

    function automatic logic [6:0] chip_cycles(input logic [1:0] chip);
        case (chip)
            `CHIP_6567R8:   return `CYCLES_R8;
            `CHIP_6567R56A: return `CYCLES_R56A;
            default:        return `CYCLES_6569;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== rtl/vic_clock_phase.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vic_defines.svh"

module vic_clock_phase
    import vic_pkg::*;
(
    input  wire logic       clk_dot4x,
    input  wire logic       rst,
    input  wire logic [1:0] chip,
    output dot_timing_t     timing
);

    // Position of clk_dot4x within the current CPU cycle
    logic [`PHASE_BITS-1:0] phase;

    // CPU cycle within the raster line
    logic [6:0] cycle;
    logic [6:0] last_cycle;
    logic       phase_wrap;

    assign last_cycle = chip_cycles(chip) - 7'd1;
    assign phase_wrap = &phase;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase <= '0;
        end else begin
            phase <= phase + `PHASE_BITS'(1);
        end
    end

    // Cycle number steps when the phase counter wraps to 0
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            cycle <= 7'd0;
        end else if (phase_wrap) begin
            if (cycle == last_cycle) begin
                cycle <= 7'd0;
            end else begin
                cycle <= cycle + 7'd1;
            end
        end
    end

    // Phi low for the first half of the CPU cycle, high for the second
    assign timing.clk_phi = phase[`PHASE_BITS-1];

    // Dot strobes land at phases 3, 7, ... and 1, 5, ... respectively
    // so dot_rising_2 trails dot_rising_0 by two clocks
    assign timing.dot_rising_0 = (phase[1:0] == 2'b11);
    assign timing.dot_rising_2 = (phase[1:0] == 2'b01);

    assign timing.cycle_num = cycle;

endmodule

`default_nettype wire

// ==== rtl/vic_raster.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vic_defines.svh"

module vic_raster
    import vic_pkg::*;
(
    input  wire logic        clk_dot4x,
    input  wire logic        rst,
    input  wire logic [1:0]  chip,
    input  wire dot_timing_t timing,
    output raster_pos_t      pos
);

    logic [9:0] x_max;
    logic [8:0] y_max;
    logic [9:0] xpos_start;
    logic [9:0] sprite_start;
    logic [9:0] xpos_step;

    // Pixel number within the CPU cycle, 0 to 7
    logic [2:0] cycle_bit;

    // Pending raster_line_d updates, applied in the next phi-low half
    logic start_of_line;
    logic start_of_frame;

    assign x_max = chip_x_max(chip);
    assign y_max = chip_y_max(chip);
    assign cycle_bit = pos.raster_x[2:0];

    assign xpos_start = (chip == `CHIP_6569 || chip == `CHIP_UNUSED) ?
                        `XPOS_START_PAL : `XPOS_START_NTSC;

    // Places sprite_raster_x at 0 on the first sprite fetch cycle
    // R8 has 55 cycles before it in a 520 dot line, the others 72 dots short
    assign sprite_start = (chip == `CHIP_6567R8) ? 10'd80 : 10'd72;

    // Next xpos inside the line, including the chip specific jumps
    always_comb begin
        xpos_step = pos.xpos + 10'd1;
        if (timing.cycle_num == 7'd0 && cycle_bit == 3'd0) begin
            xpos_step = xpos_start + 10'd1;
        end else if (timing.cycle_num == 7'd12 && cycle_bit == 3'd3) begin
            xpos_step = 10'd0;
        end else if (chip == `CHIP_6567R8) begin
            // R8 holds xpos for its two extra cycles
            if (timing.cycle_num == 7'd60 && cycle_bit == 3'd7) begin
                xpos_step = `XPOS_HOLD_R8;
            end else if (timing.cycle_num == 7'd61 &&
                         (cycle_bit == 3'd3 || cycle_bit == 3'd7)) begin
                xpos_step = `XPOS_HOLD_R8;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pos.xpos            <= xpos_start;
            pos.raster_x        <= 10'd0;
            pos.sprite_raster_x <= sprite_start;
            pos.raster_line     <= 9'd0;
            pos.raster_line_d   <= 9'd0;
            pos.hires_raster_x  <= 11'd0;
            pos.blink_ctr       <= 7'd0;
            start_of_line       <= 1'b0;
            start_of_frame      <= 1'b0;
        end else begin
            // Delayed line copy moves in the phi-low half
            if (!timing.clk_phi && start_of_line) begin
                pos.raster_line_d <= pos.raster_line;
                start_of_line     <= 1'b0;
            end

            if (!timing.clk_phi && start_of_frame && timing.cycle_num == 7'd1) begin
                pos.raster_line_d <= 9'd0;
                start_of_frame    <= 1'b0;
            end

            if (timing.dot_rising_0) begin
                if (pos.raster_x < x_max) begin
                    pos.raster_x       <= pos.raster_x + 10'd1;
                    pos.hires_raster_x <= pos.hires_raster_x + 11'd1;
                    pos.xpos           <= xpos_step;
                end else begin
                    // End of line
                    pos.raster_x       <= 10'd0;
                    pos.hires_raster_x <= 11'd0;
                    pos.xpos           <= xpos_start;

                    if (pos.raster_line < y_max) begin
                        pos.raster_line <= pos.raster_line + 9'd1;
                        start_of_line   <= 1'b1;
                    end else begin
                        pos.raster_line <= 9'd0;
                        start_of_frame  <= 1'b1;
                        // Frame count for the hires blink attribute
                        pos.blink_ctr   <= pos.blink_ctr + 7'd1;
                    end
                end

                if (pos.sprite_raster_x < x_max) begin
                    pos.sprite_raster_x <= pos.sprite_raster_x + 10'd1;
                end else begin
                    pos.sprite_raster_x <= 10'd0;
                end
            end

            // Second half dot for hires, never in the same clock as dot_rising_0
            if (timing.dot_rising_2) begin
                pos.hires_raster_x <= pos.hires_raster_x + 11'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vic_raster_irq.sv ====
`timescale 1ns/1ns
`default_nettype none

module vic_raster_irq
    import vic_pkg::*;
(
    input  wire logic        clk_dot4x,
    input  wire logic        rst,
    input  wire raster_pos_t pos,
    input  wire logic        reg_we,
    input  wire logic [8:0]  reg_line,
    input  wire logic        irq_ack,
    output logic             irq
);

    // Programmed compare line
    logic [8:0] cmp_line;

    // raster_line as of the previous clock
    logic [8:0] prev_line;
    logic       line_hit;

    // Only a fresh line value can match, so a write alone never fires
    assign line_hit = (pos.raster_line != prev_line) &&
                      (pos.raster_line == cmp_line);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            cmp_line  <= 9'd0;
            prev_line <= 9'd0;
        end else begin
            prev_line <= pos.raster_line;
            if (reg_we) begin
                cmp_line <= reg_line;
            end
        end
    end

    // A hit wins over an acknowledge in the same clock
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irq <= 1'b0;
        end else if (line_hit) begin
            irq <= 1'b1;
        end else if (irq_ack) begin
            irq <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vic_timing_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module vic_timing_top
    import vic_pkg::*;
(
    input  wire logic        clk_dot4x,
    input  wire logic        rst,
    input  wire logic [1:0]  chip,
    input  wire logic        reg_we,
    input  wire logic [8:0]  reg_line,
    input  wire logic        irq_ack,
    output wire dot_timing_t timing,
    output wire raster_pos_t pos,
    output wire logic        irq
);

    // Dot strobes, phi and cycle number
    vic_clock_phase u_clock_phase (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip      (chip),
        .timing    (timing)
    );

    // Beam position
    vic_raster u_raster (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip      (chip),
        .timing    (timing),
        .pos       (pos)
    );

    // Raster compare interrupt
    vic_raster_irq u_raster_irq (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .pos       (pos),
        .reg_we    (reg_we),
        .reg_line  (reg_line),
        .irq_ack   (irq_ack),
        .irq       (irq)
    );

endmodule

`default_nettype wire

// ==== dv/tb_vic_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vic_defines.svh"

module tb_vic_timing
    import vic_pkg::*;
();

    // Frame wrap and the IRQ wait each take up to one PAL frame of 312 x 2016 clocks
    localparam int unsigned MAX_CYCLES = 2000000;

    logic        clk_dot4x = 1'b0;
    logic        rst;
    logic [1:0]  chip;
    logic        reg_we;
    logic [8:0]  reg_line;
    logic        irq_ack;
    dot_timing_t timing;
    raster_pos_t pos;
    logic        irq;

    // Reference model state
    logic [1:0]  m_chip;
    logic [4:0]  m_phase;
    logic [6:0]  m_cycle;
    logic [9:0]  m_x;
    logic [9:0]  m_sx;
    logic [8:0]  m_line;
    logic [8:0]  m_line_d;
    logic [10:0] m_hires;
    logic [6:0]  m_blink;
    logic        line_pending;
    logic        frame_pending;

    int unsigned cycle_count = 0;

    vic_timing_top dut (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip      (chip),
        .reg_we    (reg_we),
        .reg_line  (reg_line),
        .irq_ack   (irq_ack),
        .timing    (timing),
        .pos       (pos),
        .irq       (irq)
    );

    always #4 clk_dot4x = ~clk_dot4x;

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    always @(posedge clk_dot4x) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run went past %0d clock cycles", MAX_CYCLES);
            stop_run();
        end
    end

    task automatic check_pos(input string name, input raster_pos_t exp, input raster_pos_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %p, actual %p", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_timing(input string name, input dot_timing_t exp,
                                input dot_timing_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %p, actual %p", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %0b, actual %0b", name, exp, act);
            stop_run();
        end
    endtask

    function automatic logic [9:0] xpos_start(input logic [1:0] c);
        return (c == `CHIP_6569 || c == `CHIP_UNUSED) ? `XPOS_START_PAL : `XPOS_START_NTSC;
    endfunction

    // xpos for a given raster_x, with the jumps at cycles 0, 12 and R8 cycles 60, 61
    function automatic logic [9:0] xpos_model(input logic [1:0] c, input logic [9:0] x);
        if (x < 10'd100) begin
            return xpos_start(c) + x;
        end
        if (c == `CHIP_6567R8 && x >= 10'd488 && x < 10'd496) begin
            return `XPOS_HOLD_R8 + {8'd0, x[1:0]};
        end
        if (c == `CHIP_6567R8 && x >= 10'd496) begin
            return x - 10'd108;
        end
        return x - 10'd100;
    endfunction

    function automatic dot_timing_t modeled_timing();
        dot_timing_t t;
        t.clk_phi      = (m_phase >= 5'd16);
        t.dot_rising_0 = (m_phase[1:0] == 2'b11);
        t.dot_rising_2 = (m_phase[1:0] == 2'b01);
        t.cycle_num    = m_cycle;
        return t;
    endfunction

    function automatic raster_pos_t modeled_pos();
        raster_pos_t p;
        p.xpos            = xpos_model(m_chip, m_x);
        p.raster_x        = m_x;
        p.sprite_raster_x = m_sx;
        p.raster_line     = m_line;
        p.raster_line_d   = m_line_d;
        p.hires_raster_x  = m_hires;
        p.blink_ctr       = m_blink;
        return p;
    endfunction

    // One clk_dot4x edge of the reference model
    task automatic advance_model();
        logic [4:0] p;
        p = m_phase;
        if (p < 5'd16 && line_pending) begin
            m_line_d = m_line;
            line_pending = 1'b0;
        end
        if (p < 5'd16 && frame_pending && m_cycle == 7'd1) begin
            m_line_d = 9'd0;
            frame_pending = 1'b0;
        end
        if (p[1:0] == 2'b11) begin
            if (m_x == chip_x_max(m_chip)) begin
                m_x = 10'd0;
                m_hires = 11'd0;
                if (m_line == chip_y_max(m_chip)) begin
                    m_line = 9'd0;
                    m_blink = m_blink + 7'd1;
                    frame_pending = 1'b1;
                end else begin
                    m_line = m_line + 9'd1;
                    line_pending = 1'b1;
                end
            end else begin
                m_x = m_x + 10'd1;
                m_hires = m_hires + 11'd1;
            end
            m_sx = (m_sx == chip_x_max(m_chip)) ? 10'd0 : m_sx + 10'd1;
        end
        if (p[1:0] == 2'b01) begin
            m_hires = m_hires + 11'd1;
        end
        if (p == 5'd31) begin
            m_cycle = (m_cycle == chip_cycles(m_chip) - 7'd1) ? 7'd0 : m_cycle + 7'd1;
        end
        m_phase = p + 5'd1;
    endtask

    // Advance one clock and compare against the model
    task automatic tick(input string name);
        @(negedge clk_dot4x);
        advance_model();
        check_timing(name, modeled_timing(), timing);
        check_pos(name, modeled_pos(), pos);
    endtask

    task automatic reset_dut(input logic [1:0] c);
        @(negedge clk_dot4x);
        rst  = 1'b1;
        chip = c;
        repeat (8) @(negedge clk_dot4x);
        rst = 1'b0;
        m_chip = c;
        m_phase = 5'd0;
        m_cycle = 7'd0;
        m_x = 10'd0;
        m_sx = (c == `CHIP_6567R8) ? 10'd80 : 10'd72;
        m_line = 9'd0;
        m_line_d = 9'd0;
        m_hires = 11'd0;
        m_blink = 7'd0;
        line_pending = 1'b0;
        frame_pending = 1'b0;
    endtask

    task automatic reset_state(input logic [1:0] c);
        raster_pos_t exp;
        reset_dut(c);
        exp = '0;
        exp.xpos = xpos_start(c);
        exp.sprite_raster_x = (c == `CHIP_6567R8) ? 10'd80 : 10'd72;
        check_timing("reset state", '0, timing);
        check_pos("reset state", exp, pos);
        check_bit("reset state irq", 1'b0, irq);
    endtask

    task automatic phase_cadence();
        logic [6:0] last;
        last = chip_cycles(m_chip) - 7'd1;
        while (timing.cycle_num != last) tick("phase cadence");
        while (timing.cycle_num == last) tick("phase cadence");
    endtask

    task automatic line_scan();
        logic [8:0] target;
        target = pos.raster_line + 9'd2;
        while (pos.raster_line != target) tick("line scan");
    endtask

    // Two hires steps per dot, so hires is 2x+1 whenever dot_rising_0 shows
    task automatic hires_count();
        raster_pos_t exp;
        logic [8:0]  line;
        line = pos.raster_line;
        while (pos.raster_line == line) begin
            tick("hires count");
            if (timing.dot_rising_0) begin
                exp = modeled_pos();
                exp.hires_raster_x = {m_x, 1'b1};
                check_pos("hires count", exp, pos);
            end
        end
        exp = modeled_pos();
        exp.raster_x = 10'd0;
        exp.hires_raster_x = 11'd0;
        check_pos("hires line wrap", exp, pos);
    endtask

    task automatic chip_suite(input logic [1:0] c);
        reset_state(c);
        phase_cadence();
        line_scan();
        hires_count();
    endtask

    task automatic frame_wrap();
        raster_pos_t exp;
        dot_timing_t exp_t;
        reset_dut(`CHIP_6569);
        while (pos.raster_line != chip_y_max(m_chip)) tick("frame wrap");
        while (pos.raster_line != 9'd0) tick("frame wrap");
        exp = modeled_pos();
        exp.blink_ctr = 7'd1;
        check_pos("frame blink", exp, pos);
        while (pos.raster_line_d != 9'd0) tick("frame wrap");
        exp_t = modeled_timing();
        exp_t.clk_phi = 1'b0;
        exp_t.cycle_num = 7'd1;
        check_timing("frame line_d clear", exp_t, timing);
    endtask

    task automatic write_compare(input logic [8:0] line);
        reg_we   = 1'b1;
        reg_line = line;
        tick("compare write");
        reg_we = 1'b0;
    endtask

    task automatic ack_irq();
        irq_ack = 1'b1;
        tick("irq ack");
        irq_ack = 1'b0;
    endtask

    task automatic raster_irq();
        logic [8:0]  target;
        int unsigned rnd;
        // The wrap onto line 0 may have matched the reset compare value
        ack_irq();
        check_bit("irq cleared", 1'b0, irq);
        // Compare on the current line must not fire without a line change
        write_compare(pos.raster_line);
        repeat (64) begin
            tick("irq write only");
            check_bit("irq write only", 1'b0, irq);
        end
        rnd = $urandom % 32'(chip_y_max(m_chip));
        target = 9'(rnd) + 9'd1;
        write_compare(target);
        while (pos.raster_line != target) begin
            check_bit("irq unmatched line", 1'b0, irq);
            tick("irq wait");
        end
        check_bit("irq before rise", 1'b0, irq);
        tick("irq rise");
        check_bit("irq rise", 1'b1, irq);
        repeat (16) begin
            tick("irq hold");
            check_bit("irq hold", 1'b1, irq);
        end
        ack_irq();
        check_bit("irq after ack", 1'b0, irq);
        while (pos.raster_line == target) begin
            tick("irq after ack");
            check_bit("irq after ack", 1'b0, irq);
        end
    endtask

    initial begin
        rst      = 1'b1;
        chip     = `CHIP_6569;
        reg_we   = 1'b0;
        reg_line = 9'd0;
        irq_ack  = 1'b0;
        void'($urandom(32'h0e603970));

        reset_state(`CHIP_UNUSED);
        chip_suite(`CHIP_6569);
        chip_suite(`CHIP_6567R8);
        chip_suite(`CHIP_6567R56A);
        frame_wrap();
        raster_irq();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/vic_pkg.sv
rtl/vic_clock_phase.sv
rtl/vic_raster.sv
rtl/vic_raster_irq.sv
rtl/vic_timing_top.sv
dv/tb_vic_timing.sv

// ==== Makefile ====
# Verilator build and run for the VIC-II timing core

VERILATOR ?= verilator
TOP       ?= tb_vic_timing
FILELIST  ?= vlog.f
OBJ_DIR   ?= ./obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
PASS_MSG  ?= Test passed

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard rtl/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench printed the pass line
test: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
